// File: include/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// register file sizes
`define NUM_ARCH_REGS 16
`define NUM_PHYS_REGS 32

// micro-op queue depth, counted in pairs
`define UOP_QUEUE_DEPTH 4

// reorder buffer depth, one micro-op per entry
`define ROB_DEPTH 8

`endif

// File: hw/rename_pkg.sv
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

  // index widths follow the sizes in the defines header
  localparam int ARCH_IDX_W = $clog2(`NUM_ARCH_REGS);
  localparam int PHYS_IDX_W = $clog2(`NUM_PHYS_REGS);
  localparam int ROB_IDX_W  = $clog2(`ROB_DEPTH);

  typedef logic [ARCH_IDX_W-1:0] arch_idx_t;
  typedef logic [PHYS_IDX_W-1:0] phys_idx_t;
  typedef logic [ROB_IDX_W-1:0]  rob_idx_t;

  // bit 1 marks the immediate forms
  typedef enum logic [1:0] {
    op_add  = 2'b00,
    op_sub  = 2'b01,
    op_addi = 2'b10,
    op_subi = 2'b11
  } uop_op_e;

  typedef enum logic {
    st_empty  = 1'b0,
    st_issued = 1'b1
  } rob_status_e;

endpackage

`default_nettype wire

// File: hw/uop_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module uop_queue (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 in_valid,
  input  wire rename_pkg::uop_op_e  in_op0, in_op1,
  input  wire rename_pkg::arch_idx_t in_dst0, in_dst1,
  input  wire rename_pkg::arch_idx_t in_src1_0, in_src1_1,
  input  wire rename_pkg::arch_idx_t in_src2_0, in_src2_1,
  input  wire logic [15:0]          in_imm0, in_imm1,
  input  wire logic [31:0]          in_pc0, in_pc1,
  output logic                      in_ready,
  output logic                      q_valid,
  output rename_pkg::uop_op_e       q_op0, q_op1,
  output rename_pkg::arch_idx_t     q_dst0, q_dst1,
  output rename_pkg::arch_idx_t     q_src1_0, q_src1_1,
  output rename_pkg::arch_idx_t     q_src2_0, q_src2_1,
  output logic [15:0]               q_imm0, q_imm1,
  output logic [31:0]               q_pc0, q_pc1,
  input  wire logic                 q_pop
);
  import rename_pkg::*;

  localparam int DEPTH = `UOP_QUEUE_DEPTH;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = PW + 1;

  typedef struct packed {
    uop_op_e     op;
    arch_idx_t   dst;
    arch_idx_t   src1;
    arch_idx_t   src2;
    logic [15:0] imm;
    logic [31:0] pc;
  } uop_t;

  uop_t          mem0 [DEPTH];  // lane 0, the older one
  uop_t          mem1 [DEPTH];
  uop_t          head0, head1;
  logic [PW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;
  logic          push, pop;

  assign in_ready = count != CW'(DEPTH);
  assign q_valid  = count != '0;
  assign push     = in_valid && in_ready;
  assign pop      = q_pop && q_valid;

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + PW'(1);
      if (pop) rd_ptr <= rd_ptr + PW'(1);
      count <= count + CW'(push) - CW'(pop);  // push and pop may coincide
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem0[wr_ptr] <= '{op: in_op0, dst: in_dst0, src1: in_src1_0, src2: in_src2_0,
                        imm: in_imm0, pc: in_pc0};
      mem1[wr_ptr] <= '{op: in_op1, dst: in_dst1, src1: in_src1_1, src2: in_src2_1,
                        imm: in_imm1, pc: in_pc1};
    end
  end

  assign head0 = mem0[rd_ptr];
  assign head1 = mem1[rd_ptr];

  assign q_op0    = head0.op;
  assign q_dst0   = head0.dst;
  assign q_src1_0 = head0.src1;
  assign q_src2_0 = head0.src2;
  assign q_imm0   = head0.imm;
  assign q_pc0    = head0.pc;
  assign q_op1    = head1.op;
  assign q_dst1   = head1.dst;
  assign q_src1_1 = head1.src1;
  assign q_src2_1 = head1.src2;
  assign q_imm1   = head1.imm;
  assign q_pc1    = head1.pc;

endmodule

`default_nettype wire

// File: hw/free_list.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module free_list (
  input  wire logic                  clk,
  input  wire logic                  rst,
  output logic                       frl_valid,
  output rename_pkg::phys_idx_t      free_reg0,
  output rename_pkg::phys_idx_t      free_reg1,
  output rename_pkg::phys_idx_t      free_reg2,
  output rename_pkg::phys_idx_t      free_reg3,
  input  wire logic                  frl_take0,
  input  wire logic                  frl_take1,
  input  wire logic                  frl_take2,
  input  wire logic                  frl_take3,
  input  wire logic                  ret0_valid,
  input  wire rename_pkg::phys_idx_t ret0_reg,
  input  wire logic                  ret1_valid,
  input  wire rename_pkg::phys_idx_t ret1_reg
);
  import rename_pkg::*;

  // only the registers beyond the architectural set ever circulate
  localparam int DEPTH = `NUM_PHYS_REGS - `NUM_ARCH_REGS;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = PW + 1;

  phys_idx_t     fifo [DEPTH];
  logic [PW-1:0] head, tail;
  logic [CW-1:0] count;
  logic [2:0]    n_take;
  logic [1:0]    n_ret;

  // takes are counted, not placed, so a lone take3 eats head 2
  assign n_take = 3'(frl_take0) + 3'(frl_take1) + 3'(frl_take2) + 3'(frl_take3);
  assign n_ret  = 2'(ret0_valid) + 2'(ret1_valid);

  assign frl_valid = count >= CW'(4);  // a full pair can always be served

  assign free_reg0 = fifo[head];
  assign free_reg1 = fifo[head + PW'(1)];
  assign free_reg2 = fifo[head + PW'(2)];
  assign free_reg3 = fifo[head + PW'(3)];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        fifo[i] <= phys_idx_t'(`NUM_ARCH_REGS + i);  // 16..31 ascending
      end
      head  <= '0;
      tail  <= '0;  // full, so tail meets head
      count <= CW'(DEPTH);
    end else begin
      if (ret0_valid) fifo[tail] <= ret0_reg;
      if (ret1_valid) fifo[tail + PW'(ret0_valid)] <= ret1_reg;  // ret0 goes first
      head  <= head + PW'(n_take);
      tail  <= tail + PW'(n_ret);
      count <= count - CW'(n_take) + CW'(n_ret);
    end
  end

endmodule

`default_nettype wire

// File: hw/rat.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module rat (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  q_valid,
  input  wire rename_pkg::uop_op_e   q_op0, q_op1,
  input  wire rename_pkg::arch_idx_t q_dst0, q_dst1,
  input  wire rename_pkg::arch_idx_t q_src1_0, q_src1_1,
  input  wire rename_pkg::arch_idx_t q_src2_0, q_src2_1,
  input  wire logic [15:0]           q_imm0, q_imm1,
  input  wire logic [31:0]           q_pc0, q_pc1,
  output logic                       q_pop,
  input  wire logic                  frl_valid,
  input  wire rename_pkg::phys_idx_t free_reg0, free_reg1, free_reg2, free_reg3,
  output logic                       frl_take0, frl_take1, frl_take2, frl_take3,
  input  wire logic                  rob_ready,
  output logic                       rob_wr_valid,
  output logic [31:0]                wr_pc0, wr_pc1,
  output rename_pkg::arch_idx_t      wr_dst0, wr_dst1,
  output rename_pkg::phys_idx_t      wr_dst_phys0, wr_dst_phys1,
  output rename_pkg::phys_idx_t      wr_old_phys0, wr_old_phys1,
  output rename_pkg::phys_idx_t      wr_src1_phys0, wr_src1_phys1,
  output rename_pkg::phys_idx_t      wr_src2_phys0, wr_src2_phys1,
  output logic                       wr_imm_valid0, wr_imm_valid1,
  output rename_pkg::phys_idx_t      wr_imm_phys0, wr_imm_phys1,
  output rename_pkg::rob_status_e    wr_status0, wr_status1,
  output logic                       rf_wr_en0, rf_wr_en1,
  output rename_pkg::phys_idx_t      rf_wr_idx0, rf_wr_idx1,
  output logic [63:0]                rf_wr_data0, rf_wr_data1
);
  import rename_pkg::*;

  phys_idx_t map [`NUM_ARCH_REGS];
  logic      progress;
  logic      imm0, imm1;
  phys_idx_t imm_reg1;
  phys_idx_t src1_p0, src2_p0, old_p0;
  phys_idx_t src1_p1, src2_p1, old_p1;

  assign progress = q_valid && frl_valid && rob_ready;
  assign imm0     = q_op0[1];
  assign imm1     = q_op1[1];

  assign q_pop     = progress;
  assign frl_take0 = progress;  // every micro-op has a destination
  assign frl_take1 = progress;
  assign frl_take2 = progress && imm0;
  assign frl_take3 = progress && imm1;

  // the free list compacts takes, so lane 1 slides down when lane 0 has no immediate
  assign imm_reg1 = imm0 ? free_reg3 : free_reg2;

  always_comb begin
    src1_p0 = map[q_src1_0];
    src2_p0 = imm0 ? free_reg2 : map[q_src2_0];
    old_p0  = map[q_dst0];
    // lane 1 sees lane 0's new destination
    src1_p1 = (q_src1_1 == q_dst0) ? free_reg0 : map[q_src1_1];
    if (imm1) src2_p1 = imm_reg1;
    else if (q_src2_1 == q_dst0) src2_p1 = free_reg0;
    else src2_p1 = map[q_src2_1];
    old_p1  = (q_dst1 == q_dst0) ? free_reg0 : map[q_dst1];
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
        map[i] <= phys_idx_t'(i);  // identity mapping
      end
      rob_wr_valid <= 1'b0;
      rf_wr_en0    <= 1'b0;
      rf_wr_en1    <= 1'b0;
    end else begin
      rob_wr_valid <= progress;
      rf_wr_en0    <= progress && imm0;
      rf_wr_en1    <= progress && imm1;
      if (progress) begin
        map[q_dst0] <= free_reg0;
        map[q_dst1] <= free_reg1;  // younger lane wins on a shared dst
      end
    end
  end

  always_ff @(posedge clk) begin
    if (progress) begin
      wr_pc0        <= q_pc0;
      wr_dst0       <= q_dst0;
      wr_dst_phys0  <= free_reg0;
      wr_old_phys0  <= old_p0;
      wr_src1_phys0 <= src1_p0;
      wr_src2_phys0 <= src2_p0;
      wr_imm_valid0 <= imm0;
      wr_imm_phys0  <= free_reg2;
      wr_status0    <= st_issued;
      wr_pc1        <= q_pc1;
      wr_dst1       <= q_dst1;
      wr_dst_phys1  <= free_reg1;
      wr_old_phys1  <= old_p1;
      wr_src1_phys1 <= src1_p1;
      wr_src2_phys1 <= src2_p1;
      wr_imm_valid1 <= imm1;
      wr_imm_phys1  <= imm_reg1;
      wr_status1    <= st_issued;
      rf_wr_idx0    <= free_reg2;
      rf_wr_data0   <= 64'(q_imm0);  // zero extended
      rf_wr_idx1    <= imm_reg1;
      rf_wr_data1   <= 64'(q_imm1);
    end
  end

endmodule

`default_nettype wire

// File: hw/rob.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module rob (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    rob_wr_valid,
  input  wire logic [31:0]             wr_pc0, wr_pc1,
  input  wire rename_pkg::arch_idx_t   wr_dst0, wr_dst1,
  input  wire rename_pkg::phys_idx_t   wr_dst_phys0, wr_dst_phys1,
  input  wire rename_pkg::phys_idx_t   wr_old_phys0, wr_old_phys1,
  input  wire rename_pkg::phys_idx_t   wr_src1_phys0, wr_src1_phys1,
  input  wire rename_pkg::phys_idx_t   wr_src2_phys0, wr_src2_phys1,
  input  wire logic                    wr_imm_valid0, wr_imm_valid1,
  input  wire rename_pkg::phys_idx_t   wr_imm_phys0, wr_imm_phys1,
  input  wire rename_pkg::rob_status_e wr_status0, wr_status1,
  output logic                         rob_ready,
  output logic                         commit_valid,
  input  wire logic                    commit_ready,
  output logic [31:0]                  commit_pc,
  output rename_pkg::arch_idx_t        commit_dst,
  output rename_pkg::phys_idx_t        commit_phys,
  output rename_pkg::phys_idx_t        commit_src1_phys,
  output rename_pkg::phys_idx_t        commit_src2_phys,
  output logic                         ret0_valid,
  output rename_pkg::phys_idx_t        ret0_reg,
  output logic                         ret1_valid,
  output rename_pkg::phys_idx_t        ret1_reg
);
  import rename_pkg::*;

  localparam int DEPTH = `ROB_DEPTH;
  localparam int CW    = ROB_IDX_W + 1;

  rob_status_e   status [DEPTH];
  logic [31:0]   pc [DEPTH];
  arch_idx_t     dst [DEPTH];
  phys_idx_t     dst_phys [DEPTH];
  phys_idx_t     old_phys [DEPTH];
  phys_idx_t     src1_phys [DEPTH];
  phys_idx_t     src2_phys [DEPTH];
  logic          imm_valid [DEPTH];
  phys_idx_t     imm_phys [DEPTH];
  rob_idx_t      head, tail;
  logic [CW-1:0] count;
  logic          retire;

  // four free entries, since one pair may already be in flight from the rat
  assign rob_ready    = count <= CW'(DEPTH - 4);
  assign commit_valid = status[head] == st_issued;
  assign retire       = commit_valid && commit_ready;

  assign commit_pc        = pc[head];
  assign commit_dst       = dst[head];
  assign commit_phys      = dst_phys[head];
  assign commit_src1_phys = src1_phys[head];
  assign commit_src2_phys = src2_phys[head];

  // freed registers go back on the retire edge
  assign ret0_valid = retire;
  assign ret0_reg   = old_phys[head];
  assign ret1_valid = retire && imm_valid[head];
  assign ret1_reg   = imm_phys[head];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        status[i] <= st_empty;
      end
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (rob_wr_valid) begin
        status[tail]                 <= wr_status0;  // lane 0 first
        status[tail + rob_idx_t'(1)] <= wr_status1;
        tail                         <= tail + rob_idx_t'(2);
      end
      if (retire) begin
        status[head] <= st_empty;
        head         <= head + rob_idx_t'(1);
      end
      count <= count + (rob_wr_valid ? CW'(2) : CW'(0)) - CW'(retire);
    end
  end

  always_ff @(posedge clk) begin
    if (rob_wr_valid) begin
      pc[tail]                        <= wr_pc0;
      dst[tail]                       <= wr_dst0;
      dst_phys[tail]                  <= wr_dst_phys0;
      old_phys[tail]                  <= wr_old_phys0;
      src1_phys[tail]                 <= wr_src1_phys0;
      src2_phys[tail]                 <= wr_src2_phys0;
      imm_valid[tail]                 <= wr_imm_valid0;
      imm_phys[tail]                  <= wr_imm_phys0;
      pc[tail + rob_idx_t'(1)]        <= wr_pc1;
      dst[tail + rob_idx_t'(1)]       <= wr_dst1;
      dst_phys[tail + rob_idx_t'(1)]  <= wr_dst_phys1;
      old_phys[tail + rob_idx_t'(1)]  <= wr_old_phys1;
      src1_phys[tail + rob_idx_t'(1)] <= wr_src1_phys1;
      src2_phys[tail + rob_idx_t'(1)] <= wr_src2_phys1;
      imm_valid[tail + rob_idx_t'(1)] <= wr_imm_valid1;
      imm_phys[tail + rob_idx_t'(1)]  <= wr_imm_phys1;
    end
  end

endmodule

`default_nettype wire

// File: hw/rename_top.sv
`timescale 1ns/1ns
`default_nettype none

module rename_top (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  in_valid,
  input  wire rename_pkg::uop_op_e   in_op0, in_op1,
  input  wire rename_pkg::arch_idx_t in_dst0, in_dst1,
  input  wire rename_pkg::arch_idx_t in_src1_0, in_src1_1,
  input  wire rename_pkg::arch_idx_t in_src2_0, in_src2_1,
  input  wire logic [15:0]           in_imm0, in_imm1,
  input  wire logic [31:0]           in_pc0, in_pc1,
  output logic                       in_ready,
  output logic                       commit_valid,
  input  wire logic                  commit_ready,
  output logic [31:0]                commit_pc,
  output rename_pkg::arch_idx_t      commit_dst,
  output rename_pkg::phys_idx_t      commit_phys,
  output rename_pkg::phys_idx_t      commit_src1_phys,
  output rename_pkg::phys_idx_t      commit_src2_phys,
  output logic                       rf_wr_en0, rf_wr_en1,
  output rename_pkg::phys_idx_t      rf_wr_idx0, rf_wr_idx1,
  output logic [63:0]                rf_wr_data0, rf_wr_data1
);
  import rename_pkg::*;

  // queue head pair
  logic        q_valid, q_pop;
  uop_op_e     q_op0, q_op1;
  arch_idx_t   q_dst0, q_dst1, q_src1_0, q_src1_1, q_src2_0, q_src2_1;
  logic [15:0] q_imm0, q_imm1;
  logic [31:0] q_pc0, q_pc1;

  // free list heads and takes
  logic        frl_valid;
  phys_idx_t   free_reg0, free_reg1, free_reg2, free_reg3;
  logic        frl_take0, frl_take1, frl_take2, frl_take3;

  // renamed pair into the reorder buffer
  logic        rob_ready, rob_wr_valid;
  logic [31:0] wr_pc0, wr_pc1;
  arch_idx_t   wr_dst0, wr_dst1;
  phys_idx_t   wr_dst_phys0, wr_dst_phys1, wr_old_phys0, wr_old_phys1;
  phys_idx_t   wr_src1_phys0, wr_src1_phys1, wr_src2_phys0, wr_src2_phys1;
  logic        wr_imm_valid0, wr_imm_valid1;
  phys_idx_t   wr_imm_phys0, wr_imm_phys1;
  rob_status_e wr_status0, wr_status1;

  // retired registers back to the free list
  logic        ret0_valid, ret1_valid;
  phys_idx_t   ret0_reg, ret1_reg;

  uop_queue u_queue (.*);
  free_list u_free_list (.*);
  rat       u_rat (.*);
  rob       u_rob (.*);

endmodule

`default_nettype wire

// File: sim/rename_chk.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module rename_chk (
  input wire logic                  clk,
  input wire logic                  rst,
  input wire logic                  in_valid,
  input wire logic                  in_ready,
  input wire rename_pkg::uop_op_e   in_op0, in_op1,
  input wire rename_pkg::arch_idx_t in_dst0, in_dst1,
  input wire logic [15:0]           in_imm0, in_imm1,
  input wire logic [31:0]           in_pc0, in_pc1,
  input wire logic                  commit_valid,
  input wire logic                  commit_ready,
  input wire logic [31:0]           commit_pc,
  input wire rename_pkg::phys_idx_t commit_phys,
  input wire logic                  frl_take0, frl_take1, frl_take2, frl_take3,
  input wire logic                  ret0_valid, ret1_valid,
  input wire logic                  rob_wr_valid
);
  import rename_pkg::*;

  localparam int FREE_MAX = `NUM_PHYS_REGS - `NUM_ARCH_REGS;

  logic [5:0] free_cnt;  // shadow of the free list occupancy
  logic [4:0] rob_cnt;
  logic       retire;

  assign retire = commit_valid && commit_ready;

  always_ff @(posedge clk) begin
    if (!rst) begin
      free_cnt <= 6'(FREE_MAX);
      rob_cnt  <= '0;
    end else begin
      free_cnt <= free_cnt - 6'(frl_take0) - 6'(frl_take1) - 6'(frl_take2) - 6'(frl_take3)
                  + 6'(ret0_valid) + 6'(ret1_valid);
      rob_cnt  <= rob_cnt + (rob_wr_valid ? 5'd2 : 5'd0) - 5'(retire);
    end
  end

  in_hold: assert property (@(posedge clk) disable iff (!rst)
    in_valid && !in_ready |=> in_valid &&
      $stable({in_op0, in_op1, in_dst0, in_dst1, in_imm0, in_imm1, in_pc0, in_pc1}))
    else $error("input pair dropped or changed before acceptance");

  commit_hold: assert property (@(posedge clk) disable iff (!rst)
    commit_valid && !commit_ready |=> commit_valid && $stable({commit_pc, commit_phys}))
    else $error("commit dropped or changed before acceptance");

  // underflow wraps high, so this catches both directions
  free_bound: assert property (@(posedge clk) disable iff (!rst) free_cnt <= 6'(FREE_MAX))
    else $error("free list count out of range");

  rob_room: assert property (@(posedge clk) disable iff (!rst)
    rob_wr_valid |-> rob_cnt <= 5'(`ROB_DEPTH - 2))
    else $error("reorder buffer written with fewer than two free entries");

endmodule

`default_nettype wire

// File: sim/rename_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module rename_tb;
  import rename_pkg::*;

  localparam int NUM_PAIRS  = 300;
  localparam int NUM_UOPS   = 2 * NUM_PAIRS;
  localparam int MAX_CYCLES = NUM_PAIRS * 2 * 10;

  logic        clk, rst, in_valid, in_ready, commit_valid, commit_ready;
  uop_op_e     in_op0, in_op1;
  arch_idx_t   in_dst0, in_dst1, in_src1_0, in_src1_1, in_src2_0, in_src2_1;
  logic [15:0] in_imm0, in_imm1;
  logic [31:0] in_pc0, in_pc1, commit_pc;
  arch_idx_t   commit_dst;
  phys_idx_t   commit_phys, commit_src1_phys, commit_src2_phys;
  logic        rf_wr_en0, rf_wr_en1;
  phys_idx_t   rf_wr_idx0, rf_wr_idx1;
  logic [63:0] rf_wr_data0, rf_wr_data1;

  // stimulus and expected results, slot 2 * pair + lane
  uop_op_e     s_op [NUM_UOPS];
  arch_idx_t   s_dst [NUM_UOPS], s_src1 [NUM_UOPS], s_src2 [NUM_UOPS];
  logic [15:0] s_imm [NUM_UOPS];
  logic [31:0] s_pc [NUM_UOPS];
  phys_idx_t   e_phys [NUM_UOPS], e_old [NUM_UOPS], e_imm [NUM_UOPS];
  phys_idx_t   e_src1 [NUM_UOPS], e_src2 [NUM_UOPS];
  phys_idx_t   model_map [`NUM_ARCH_REGS];
  phys_idx_t   model_free [$];  // same order the hardware hands registers out
  int          n_sent, n_renamed, n_commits, rf_pair, cycles;
  logic        seen_full;
  logic [31:0] stim_state, ready_state;

  rename_top dut (.*);

  bind rename_top rename_chk u_chk (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
    .in_op0(in_op0), .in_op1(in_op1), .in_dst0(in_dst0), .in_dst1(in_dst1),
    .in_imm0(in_imm0), .in_imm1(in_imm1), .in_pc0(in_pc0), .in_pc1(in_pc1),
    .commit_valid(commit_valid), .commit_ready(commit_ready),
    .commit_pc(commit_pc), .commit_phys(commit_phys),
    .frl_take0(frl_take0), .frl_take1(frl_take1), .frl_take2(frl_take2),
    .frl_take3(frl_take3), .ret0_valid(ret0_valid), .ret1_valid(ret1_valid),
    .rob_wr_valid(rob_wr_valid)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic take_free(output phys_idx_t r);
    if (model_free.size() == 0) stop_run("reference free list ran empty");
    else r = model_free.pop_front();
  endtask

  // dsts first, then immediates in lane order; lane 1 sees lane 0's map update
  task automatic rename_pair(input int k);
    int u;
    for (int lane = 0; lane < 2; lane++) begin
      take_free(e_phys[2 * k + lane]);
    end
    for (int lane = 0; lane < 2; lane++) begin
      if (s_op[2 * k + lane][1]) take_free(e_imm[2 * k + lane]);
    end
    for (int lane = 0; lane < 2; lane++) begin
      u = 2 * k + lane;
      e_src1[u] = model_map[s_src1[u]];
      e_src2[u] = s_op[u][1] ? e_imm[u] : model_map[s_src2[u]];
      e_old[u]  = model_map[s_dst[u]];
      model_map[s_dst[u]] = e_phys[u];
    end
    n_renamed++;
  endtask

  task automatic ensure_renamed(input int k);
    while (n_renamed <= k) begin
      rename_pair(n_renamed);
    end
  endtask

  task automatic check_rf_write();
    int u;
    while (rf_pair < n_sent && !s_op[2 * rf_pair][1] && !s_op[2 * rf_pair + 1][1]) begin
      rf_pair++;  // pairs without immediates write nothing
    end
    if (rf_pair >= n_sent) stop_run("register file write with no immediate pending");
    else begin
      u = 2 * rf_pair;
      ensure_renamed(rf_pair);
      check_value(64'(rf_wr_en0), 64'(s_op[u][1]), "rf_wr_en0");
      check_value(64'(rf_wr_en1), 64'(s_op[u + 1][1]), "rf_wr_en1");
      if (rf_wr_en0) begin
        check_value(64'(rf_wr_idx0), 64'(e_imm[u]), "rf_wr_idx0");
        check_value(rf_wr_data0, 64'(s_imm[u]), "rf_wr_data0");
      end
      if (rf_wr_en1) begin
        check_value(64'(rf_wr_idx1), 64'(e_imm[u + 1]), "rf_wr_idx1");
        check_value(rf_wr_data1, 64'(s_imm[u + 1]), "rf_wr_data1");
      end
      rf_pair++;
    end
  endtask

  task automatic check_commit();
    int u;
    u = n_commits;
    if (u >= 2 * n_sent) stop_run("commit seen with no micro-op outstanding");
    else begin
      ensure_renamed(u / 2);
      check_value(64'(commit_pc), 64'(s_pc[u]), "commit_pc");
      check_value(64'(commit_dst), 64'(s_dst[u]), "commit_dst");
      check_value(64'(commit_phys), 64'(e_phys[u]), "commit_phys");
      check_value(64'(commit_src1_phys), 64'(e_src1[u]), "commit_src1_phys");
      check_value(64'(commit_src2_phys), 64'(e_src2[u]), "commit_src2_phys");
      if (s_op[u][1]) check_value(64'(rf_pair > u / 2), 64'd1, "immediate written before commit");
      model_free.push_back(e_old[u]);  // retired registers recycle in order
      if (s_op[u][1]) model_free.push_back(e_imm[u]);
      n_commits++;
    end
  endtask

  task automatic send_pair(input int k);
    int   gap;
    logic acc;
    stim_state = lcg_next(stim_state);
    gap = (stim_state[31:29] == 3'd0) ? int'(stim_state[28:27]) + 1 : 0;
    if (gap > 0) in_valid = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
    for (int lane = 0; lane < 2; lane++) begin
      stim_state = lcg_next(stim_state);
      s_op[2 * k + lane]   = uop_op_e'(stim_state[31:30]);
      s_dst[2 * k + lane]  = stim_state[29:26];
      s_src1[2 * k + lane] = stim_state[25:22];
      s_src2[2 * k + lane] = stim_state[21:18];
      stim_state = lcg_next(stim_state);
      s_imm[2 * k + lane]  = stim_state[31:16];
      s_pc[2 * k + lane]   = 32'h1000 + 32'(k) * 32'd8 + 32'(lane) * 32'd4;
    end
    in_op0    = s_op[2 * k];
    in_dst0   = s_dst[2 * k];
    in_src1_0 = s_src1[2 * k];
    in_src2_0 = s_src2[2 * k];
    in_imm0   = s_imm[2 * k];
    in_pc0    = s_pc[2 * k];
    in_op1    = s_op[2 * k + 1];
    in_dst1   = s_dst[2 * k + 1];
    in_src1_1 = s_src1[2 * k + 1];
    in_src2_1 = s_src2[2 * k + 1];
    in_imm1   = s_imm[2 * k + 1];
    in_pc1    = s_pc[2 * k + 1];
    n_sent    = k + 1;
    in_valid  = 1'b1;
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk);
      acc = in_ready;  // transfer happens on the coming edge
      @(posedge clk);
      #2;
    end
  endtask

  // random back-pressure plus a long stall every 300 cycles
  always @(posedge clk) begin
    #2;
    ready_state = lcg_next(ready_state);
    if (!rst || (cycles % 300) >= 240) commit_ready = 1'b0;
    else commit_ready = ready_state[31:28] >= 4'd5;
  end

  always @(negedge clk) begin
    if (rst) begin
      if (!in_ready) seen_full = 1'b1;
      if (rf_wr_en0 || rf_wr_en1) check_rf_write();
      if (commit_valid && commit_ready) check_commit();
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_run($sformatf("timeout: %0d of %0d commits seen after %0d cycles",
                         n_commits, NUM_UOPS, cycles));
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    in_valid = 1'b0;
    in_op0 = op_add;
    in_op1 = op_add;
    {in_dst0, in_dst1, in_src1_0, in_src1_1, in_src2_0, in_src2_1} = '0;
    {in_imm0, in_imm1, in_pc0, in_pc1} = '0;
    commit_ready = 1'b0;
    {n_sent, n_renamed, n_commits, rf_pair, cycles} = '0;
    seen_full = 1'b0;
    stim_state = 32'd72752;
    ready_state = 32'd72752 ^ 32'hffff_0000;
    for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
      model_map[i] = phys_idx_t'(i);  // identity at reset
    end
    for (int i = `NUM_ARCH_REGS; i < `NUM_PHYS_REGS; i++) begin
      model_free.push_back(phys_idx_t'(i));
    end
    repeat (4) @(posedge clk);
    #2 rst = 1'b1;
    @(negedge clk);
    check_value(64'(commit_valid), 64'd0, "commit_valid after reset");
    check_value(64'(rf_wr_en0), 64'd0, "rf_wr_en0 after reset");
    check_value(64'(rf_wr_en1), 64'd0, "rf_wr_en1 after reset");
    check_value(64'(in_ready), 64'd1, "in_ready after reset");
    @(posedge clk);
    #2;
    for (int k = 0; k < NUM_PAIRS; k++) begin
      send_pair(k);
    end
    in_valid = 1'b0;
    wait (n_commits == NUM_UOPS);
    check_value(64'(seen_full), 64'd1, "in_ready low under back-pressure");
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rename_top.f
+incdir+include
hw/rename_pkg.sv
hw/uop_queue.sv
hw/free_list.sv
hw/rat.sv
hw/rob.sv
hw/rename_top.sv
sim/rename_chk.sv
sim/rename_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= rename_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
